/* common/exec_config.svh */
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// lanes are filled round-robin, one issue per cycle
`define EXEC_LANES 4

`define EXEC_WORD 64 // operand and result width
`define EXEC_HALF 32 // width of one pipeline half

// destination tag, one of 64 physical registers
`define EXEC_TAG_W 6

// issue edge to result_valid edge
`define EXEC_LATENCY 4

`endif

/* common/exec_pkg.sv */
`include "exec_config.svh"

package exec_pkg;

  typedef enum logic [3:0] {
    ADD   = 4'd0,
    SUB   = 4'd1,
    AND   = 4'd2,
    OR    = 4'd3,
    XOR   = 4'd4,
    SHL   = 4'd5,
    SHR   = 4'd6,
    SAR   = 4'd7,
    SXT   = 4'd8,  // size in b[1:0]
    BSWAP = 4'd9,  // low word only
    MOVI  = 4'd10
  } alu_op_e;

  typedef enum logic [3:0] {
    COND_EQ = 4'd0,  // z
    COND_NE = 4'd1,
    COND_LT = 4'd2,  // n != v
    COND_GE = 4'd3,
    COND_CS = 4'd4,
    COND_CC = 4'd5,
    COND_MI = 4'd6,
    COND_PL = 4'd7,
    COND_VS = 4'd8,
    COND_VC = 4'd9,
    COND_HI = 4'd10, // c and not z
    COND_AL = 4'd11,
    COND_LS = 4'd12,
    COND_GT = 4'd13, // not z and n == v
    COND_LE = 4'd14,
    COND_NV = 4'd15
  } cond_e;

  typedef struct packed {
    logic carry;
    logic overflow;
    logic negative;
    logic zero;
  } flags_t;

  // operand b source in the register form
  typedef enum logic [1:0] {
    BSEL_OPND = 2'd0,
    BSEL_ONE  = 2'd1,
    BSEL_ZERO = 2'd2,
    BSEL_ONES = 2'd3
  } b_sel_e;

  typedef struct packed {
    alu_op_e                op;
    cond_e                  cond;
    logic [`EXEC_TAG_W-1:0] tag;
    logic                   is_imm; // low in this view
    b_sel_e                 b_sel;
    logic [14:0]            rsvd;
  } instr_reg_t;

  typedef struct packed {
    alu_op_e                op;
    cond_e                  cond;
    logic [`EXEC_TAG_W-1:0] tag;
    logic                   is_imm; // high in this view
    logic [16:0]            imm;    // sign extended into operand b
  } instr_imm_t;

  typedef union packed {
    instr_reg_t rg;
    instr_imm_t im;
  } instr_u;

endpackage

/* alu_lane/cond_eval.sv */
`timescale 1ns/1ps

module cond_eval (
  input  exec_pkg::cond_e  cond,
  input  exec_pkg::flags_t flags,
  output logic             cond_true
);

  logic n_ne_v;

  assign n_ne_v = flags.negative ^ flags.overflow;

  always_comb begin
    case (cond)
      exec_pkg::COND_EQ: cond_true = flags.zero;
      exec_pkg::COND_NE: cond_true = ~flags.zero;
      exec_pkg::COND_LT: cond_true = n_ne_v;
      exec_pkg::COND_GE: cond_true = ~n_ne_v;
      exec_pkg::COND_CS: cond_true = flags.carry;
      exec_pkg::COND_CC: cond_true = ~flags.carry;
      exec_pkg::COND_MI: cond_true = flags.negative;
      exec_pkg::COND_PL: cond_true = ~flags.negative;
      exec_pkg::COND_VS: cond_true = flags.overflow;
      exec_pkg::COND_VC: cond_true = ~flags.overflow;
      exec_pkg::COND_HI: cond_true = flags.carry & ~flags.zero;
      exec_pkg::COND_AL: cond_true = 1'b1;
      exec_pkg::COND_LS: cond_true = ~flags.carry | flags.zero;
      exec_pkg::COND_GT: cond_true = ~flags.zero & ~n_ne_v;
      exec_pkg::COND_LE: cond_true = flags.zero | n_ne_v;
      default:           cond_true = 1'b0; // never
    endcase
  end

endmodule

/* alu_lane/alu_lane.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module alu_lane (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  exec_pkg::alu_op_e      op,
  input  exec_pkg::cond_e        cond,
  input  logic [`EXEC_TAG_W-1:0] tag,
  input  logic [`EXEC_WORD-1:0]  opnd_a,
  input  logic [`EXEC_WORD-1:0]  opnd_b,
  input  exec_pkg::flags_t       opnd_flags,
  output logic                   done,
  output logic                   exec,
  output logic [`EXEC_TAG_W-1:0] tag_out,
  output logic [`EXEC_WORD-1:0]  result,
  output logic                   carry,
  output logic                   overflow,
  output exec_pkg::flags_t       flags_old
);

  localparam int H = `EXEC_HALF;
  localparam int W = `EXEC_WORD;

  logic         sub;
  logic [H-1:0] b_lo_x;
  logic [H:0]   sum_lo;
  logic [H-1:0] sxt_lo;
  logic [H-1:0] res_lo;
  logic         cond_true;

  logic                   s1_vld;
  exec_pkg::alu_op_e      s1_op;
  logic [`EXEC_TAG_W-1:0] s1_tag;
  logic [W-1:0]           s1_a;
  logic [W-1:0]           s1_b;
  exec_pkg::flags_t       s1_flags;
  logic [H-1:0]           s1_lo;
  logic                   s1_c;    // carry out of the low half
  logic                   s1_true;

  logic         s1_sub;
  logic         is_arith;
  logic [H-1:0] b_hi_x;
  logic [H:0]   sum_hi;
  logic         add_v;
  logic [W-1:0] shl_full;
  logic [W-1:0] shr_full;
  logic [W-1:0] sar_full;
  logic [H-1:0] sxt_hi;
  logic [H-1:0] res_hi;
  logic [W-1:0] res_full;

  cond_eval u_cond_eval (
    .cond      (cond),
    .flags     (opnd_flags),
    .cond_true (cond_true)
  );

  // stage 1, low half
  assign sub    = (op == exec_pkg::SUB);
  assign b_lo_x = opnd_b[H-1:0] ^ {H{sub}}; // subtract is a + ~b + 1
  assign sum_lo = {1'b0, opnd_a[H-1:0]} + {1'b0, b_lo_x} + {{H{1'b0}}, sub};
  assign sxt_lo = (opnd_b[1:0] == 2'd0) ? {{(H-8){opnd_a[7]}}, opnd_a[7:0]} :
                  (opnd_b[1:0] == 2'd1) ? {{(H-16){opnd_a[15]}}, opnd_a[15:0]} :
                  opnd_a[H-1:0];

  always_comb begin
    case (op)
      exec_pkg::ADD,
      exec_pkg::SUB:   res_lo = sum_lo[H-1:0];
      exec_pkg::AND:   res_lo = opnd_a[H-1:0] & opnd_b[H-1:0];
      exec_pkg::OR:    res_lo = opnd_a[H-1:0] | opnd_b[H-1:0];
      exec_pkg::XOR:   res_lo = opnd_a[H-1:0] ^ opnd_b[H-1:0];
      exec_pkg::SHL:   res_lo = opnd_b[5] ? '0 : opnd_a[H-1:0] << opnd_b[4:0];
      exec_pkg::SXT:   res_lo = sxt_lo;
      exec_pkg::BSWAP: res_lo = {opnd_a[7:0], opnd_a[15:8], opnd_a[23:16], opnd_a[31:24]};
      exec_pkg::MOVI:  res_lo = opnd_b[H-1:0];
      default:         res_lo = '0; // right shifts settle in stage 2
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_vld <= 1'b0;
      done   <= 1'b0;
    end else begin
      s1_vld <= start;
      done   <= s1_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      s1_op    <= op;
      s1_tag   <= tag;
      s1_a     <= opnd_a;
      s1_b     <= opnd_b;
      s1_flags <= opnd_flags;
      s1_lo    <= res_lo;
      s1_c     <= sum_lo[H];
      s1_true  <= cond_true;
    end
  end

  // stage 2, high half on the stored carry
  assign s1_sub   = (s1_op == exec_pkg::SUB);
  assign is_arith = (s1_op == exec_pkg::ADD) || s1_sub;
  assign b_hi_x   = s1_b[W-1:H] ^ {H{s1_sub}};
  assign sum_hi   = {1'b0, s1_a[W-1:H]} + {1'b0, b_hi_x} + {{H{1'b0}}, s1_c};
  assign add_v    = (s1_a[W-1] == b_hi_x[H-1]) && (sum_hi[H-1] != s1_a[W-1]);
  assign shl_full = s1_a << s1_b[5:0];
  assign shr_full = s1_a >> s1_b[5:0];
  assign sar_full = $signed(s1_a) >>> s1_b[5:0];

  always_comb begin
    case (s1_b[1:0])
      2'd0:    sxt_hi = {H{s1_a[7]}};
      2'd1:    sxt_hi = {H{s1_a[15]}};
      2'd2:    sxt_hi = {H{s1_a[H-1]}};
      default: sxt_hi = s1_a[W-1:H]; // size 3 keeps a
    endcase
  end

  always_comb begin
    case (s1_op)
      exec_pkg::ADD,
      exec_pkg::SUB:  res_hi = sum_hi[H-1:0];
      exec_pkg::AND:  res_hi = s1_a[W-1:H] & s1_b[W-1:H];
      exec_pkg::OR:   res_hi = s1_a[W-1:H] | s1_b[W-1:H];
      exec_pkg::XOR:  res_hi = s1_a[W-1:H] ^ s1_b[W-1:H];
      exec_pkg::SHL:  res_hi = shl_full[W-1:H];
      exec_pkg::SXT:  res_hi = sxt_hi;
      exec_pkg::MOVI: res_hi = s1_b[W-1:H];
      default:        res_hi = '0; // bswap zero extends
    endcase
  end

  always_comb begin
    if (!s1_true) begin
      res_full = s1_a; // skipped, destination keeps its value
    end else if (s1_op == exec_pkg::SHR) begin
      res_full = shr_full;
    end else if (s1_op == exec_pkg::SAR) begin
      res_full = sar_full;
    end else begin
      res_full = {res_hi, s1_lo};
    end
  end

  always_ff @(posedge clk) begin
    if (s1_vld) begin
      exec      <= s1_true;
      tag_out   <= s1_tag;
      result    <= res_full;
      carry     <= s1_true & is_arith & sum_hi[H]; // not-borrow on sub
      overflow  <= s1_true & is_arith & add_v;
      flags_old <= s1_flags;
    end
  end

endmodule

/* hdl/op_dispatch.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module op_dispatch (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   issue,
  input  exec_pkg::instr_u       instr,
  input  logic [`EXEC_WORD-1:0]  src_a,
  input  logic [`EXEC_WORD-1:0]  src_b,
  input  exec_pkg::flags_t       flags_in,
  output logic [`EXEC_LANES-1:0] lane_start,
  output exec_pkg::alu_op_e      op,
  output exec_pkg::cond_e        cond,
  output logic [`EXEC_TAG_W-1:0] tag,
  output logic [`EXEC_WORD-1:0]  opnd_a,
  output logic [`EXEC_WORD-1:0]  opnd_b,
  output exec_pkg::flags_t       opnd_flags
);

  localparam int PTR_W = $clog2(`EXEC_LANES);
  localparam logic [`EXEC_LANES-1:0] LANE0 = 1;
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`EXEC_LANES - 1);

  logic [PTR_W-1:0]      rr_ptr;
  logic [`EXEC_WORD-1:0] b_dec;

  // operand b from the immediate or from the b_sel table
  always_comb begin
    if (instr.im.is_imm) begin
      b_dec = {{(`EXEC_WORD-17){instr.im.imm[16]}}, instr.im.imm};
    end else begin
      case (instr.rg.b_sel)
        exec_pkg::BSEL_ONE:  b_dec = {{(`EXEC_WORD-1){1'b0}}, 1'b1};
        exec_pkg::BSEL_ZERO: b_dec = '0;
        exec_pkg::BSEL_ONES: b_dec = '1;
        default:             b_dec = src_b;
      endcase
    end
  end

  // round-robin steering, one start bit per issue
  always_ff @(posedge clk) begin
    if (rst) begin
      lane_start <= '0;
      rr_ptr     <= '0;
    end else begin
      lane_start <= issue ? (LANE0 << rr_ptr) : '0;
      if (issue) begin
        rr_ptr <= (rr_ptr == PTR_LAST) ? '0 : rr_ptr + 1'b1;
      end
    end
  end

  // shared fields read through the register view
  always_ff @(posedge clk) begin
    if (issue) begin
      op         <= instr.rg.op;
      cond       <= instr.rg.cond;
      tag        <= instr.rg.tag;
      opnd_a     <= src_a;
      opnd_b     <= b_dec;
      opnd_flags <= flags_in;
    end
  end

endmodule

/* hdl/result_merge.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module result_merge (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic [`EXEC_LANES-1:0]                  lane_done,
  input  logic [`EXEC_LANES-1:0]                  lane_exec,
  input  logic [`EXEC_LANES-1:0][`EXEC_TAG_W-1:0] lane_tag,
  input  logic [`EXEC_LANES-1:0][`EXEC_WORD-1:0]  lane_result,
  input  logic [`EXEC_LANES-1:0]                  lane_c,
  input  logic [`EXEC_LANES-1:0]                  lane_v,
  input  exec_pkg::flags_t [`EXEC_LANES-1:0]      lane_flags_old,
  output logic                                    result_valid,
  output logic                                    result_exec,
  output logic [`EXEC_TAG_W-1:0]                  result_tag,
  output logic [`EXEC_WORD-1:0]                   result,
  output exec_pkg::flags_t                        flags_out
);

  logic                   any_done;
  logic                   sel_exec;
  logic                   sel_c;
  logic                   sel_v;
  logic [`EXEC_TAG_W-1:0] sel_tag;
  logic [`EXEC_WORD-1:0]  sel_result;
  exec_pkg::flags_t       sel_flags_old;
  exec_pkg::flags_t       new_flags;

  assign any_done = |lane_done;

  // at most one lane finishes per cycle
  always_comb begin
    sel_exec      = 1'b0;
    sel_c         = 1'b0;
    sel_v         = 1'b0;
    sel_tag       = '0;
    sel_result    = '0;
    sel_flags_old = '0;
    for (int i = 0; i < `EXEC_LANES; i++) begin
      if (lane_done[i]) begin
        sel_exec      = lane_exec[i];
        sel_c         = lane_c[i];
        sel_v         = lane_v[i];
        sel_tag       = lane_tag[i];
        sel_result    = lane_result[i];
        sel_flags_old = lane_flags_old[i];
      end
    end
  end

  always_comb begin
    if (sel_exec) begin
      new_flags.carry    = sel_c;
      new_flags.overflow = sel_v;
      new_flags.negative = sel_result[`EXEC_WORD-1];
      new_flags.zero     = (sel_result == '0);
    end else begin
      new_flags = sel_flags_old; // skipped op leaves flags alone
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
      result_exec  <= 1'b0;
    end else begin
      result_valid <= any_done;
      result_exec  <= any_done & sel_exec;
    end
  end

  always_ff @(posedge clk) begin
    if (any_done) begin
      result_tag <= sel_tag;
      result     <= sel_result;
      flags_out  <= new_flags;
    end
  end

endmodule

/* hdl/exec_cluster.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module exec_cluster (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   issue,
  input  exec_pkg::instr_u       instr,
  input  logic [`EXEC_WORD-1:0]  src_a,
  input  logic [`EXEC_WORD-1:0]  src_b,
  input  exec_pkg::flags_t       flags_in,
  output logic                   result_valid,
  output logic                   result_exec,
  output logic [`EXEC_TAG_W-1:0] result_tag,
  output logic [`EXEC_WORD-1:0]  result,
  output exec_pkg::flags_t       flags_out
);

  // dispatch bus, shared by all lanes
  logic [`EXEC_LANES-1:0]  lane_start;
  exec_pkg::alu_op_e       op;
  exec_pkg::cond_e         cond;
  logic [`EXEC_TAG_W-1:0]  tag;
  logic [`EXEC_WORD-1:0]   opnd_a;
  logic [`EXEC_WORD-1:0]   opnd_b;
  exec_pkg::flags_t        opnd_flags;

  logic [`EXEC_LANES-1:0]                  lane_done;
  logic [`EXEC_LANES-1:0]                  lane_exec;
  logic [`EXEC_LANES-1:0][`EXEC_TAG_W-1:0] lane_tag;
  logic [`EXEC_LANES-1:0][`EXEC_WORD-1:0]  lane_result;
  logic [`EXEC_LANES-1:0]                  lane_c;
  logic [`EXEC_LANES-1:0]                  lane_v;
  exec_pkg::flags_t [`EXEC_LANES-1:0]      lane_flags_old;

  op_dispatch u_op_dispatch (
    .clk        (clk),
    .rst        (rst),
    .issue      (issue),
    .instr      (instr),
    .src_a      (src_a),
    .src_b      (src_b),
    .flags_in   (flags_in),
    .lane_start (lane_start),
    .op         (op),
    .cond       (cond),
    .tag        (tag),
    .opnd_a     (opnd_a),
    .opnd_b     (opnd_b),
    .opnd_flags (opnd_flags)
  );

  for (genvar i = 0; i < `EXEC_LANES; i++) begin : g_lane
    alu_lane u_alu_lane (
      .clk        (clk),
      .rst        (rst),
      .start      (lane_start[i]),
      .op         (op),
      .cond       (cond),
      .tag        (tag),
      .opnd_a     (opnd_a),
      .opnd_b     (opnd_b),
      .opnd_flags (opnd_flags),
      .done       (lane_done[i]),
      .exec       (lane_exec[i]),
      .tag_out    (lane_tag[i]),
      .result     (lane_result[i]),
      .carry      (lane_c[i]),
      .overflow   (lane_v[i]),
      .flags_old  (lane_flags_old[i])
    );
  end

  result_merge u_result_merge (
    .clk            (clk),
    .rst            (rst),
    .lane_done      (lane_done),
    .lane_exec      (lane_exec),
    .lane_tag       (lane_tag),
    .lane_result    (lane_result),
    .lane_c         (lane_c),
    .lane_v         (lane_v),
    .lane_flags_old (lane_flags_old),
    .result_valid   (result_valid),
    .result_exec    (result_exec),
    .result_tag     (result_tag),
    .result         (result),
    .flags_out      (flags_out)
  );

endmodule

/* testbench/exec_checker.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module exec_checker (
  input logic             clk,
  input logic             rst,
  input logic             issue,
  input logic             result_valid,
  input logic             result_exec,
  input exec_pkg::flags_t flags_in,
  input exec_pkg::flags_t flags_out
);

  int unsigned fail_count = 0; // read by the testbench
  logic        past_ok = 1'b0;

  always @(posedge clk) past_ok <= 1'b1;

  // every issue comes out after the fixed latency
  a_issue_valid: assert property (@(posedge clk) disable iff (rst)
    $past(issue, `EXEC_LATENCY) |-> result_valid)
    else begin
      $error("result_valid missing after an issue");
      fail_count++;
    end

  a_valid_issue: assert property (@(posedge clk) disable iff (rst)
    result_valid |-> $past(issue, `EXEC_LATENCY))
    else begin
      $error("result_valid without a matching issue");
      fail_count++;
    end

  a_reset_low: assert property (@(posedge clk)
    past_ok && $past(rst) |-> !result_valid && !result_exec)
    else begin
      $error("result_valid or result_exec high in reset");
      fail_count++;
    end

  // skipped instruction passes its flags through
  a_skip_flags: assert property (@(posedge clk) disable iff (rst)
    result_valid && !result_exec |-> flags_out == $past(flags_in, `EXEC_LATENCY))
    else begin
      $error("flags changed on a skipped instruction");
      fail_count++;
    end

endmodule

bind exec_cluster exec_checker u_exec_checker (
  .clk          (clk),
  .rst          (rst),
  .issue        (issue),
  .result_valid (result_valid),
  .result_exec  (result_exec),
  .flags_in     (flags_in),
  .flags_out    (flags_out)
);

/* testbench/exec_cluster_tb.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module exec_cluster_tb;

  localparam int N_CYCLES    = 3000;
  localparam int BURST_START = 2800; // issue on every cycle from here on
  localparam int DRAIN_LIMIT = 40;

  typedef struct {
    logic [`EXEC_WORD-1:0]  result;
    logic                   exec;
    logic [`EXEC_TAG_W-1:0] tag;
    exec_pkg::flags_t       flags;
    exec_pkg::alu_op_e      op;
    exec_pkg::cond_e        cond;
    int unsigned            cyc;    // cycle that must show result_valid
  } expect_t;

  logic                   clk;
  logic                   rst;
  logic                   issue;
  exec_pkg::instr_u       instr;
  logic [`EXEC_WORD-1:0]  src_a;
  logic [`EXEC_WORD-1:0]  src_b;
  exec_pkg::flags_t       flags_in;
  logic                   result_valid;
  logic                   result_exec;
  logic [`EXEC_TAG_W-1:0] result_tag;
  logic [`EXEC_WORD-1:0]  result;
  exec_pkg::flags_t       flags_out;

  expect_t     exp_q[$];
  int unsigned cyc;

  exec_cluster u_exec_cluster (
    .clk          (clk),
    .rst          (rst),
    .issue        (issue),
    .instr        (instr),
    .src_a        (src_a),
    .src_b        (src_b),
    .flags_in     (flags_in),
    .result_valid (result_valid),
    .result_exec  (result_exec),
    .result_tag   (result_tag),
    .result       (result),
    .flags_out    (flags_out)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  task automatic abort_run();
    $display("Regression failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("** Error %s: expected %0h, actual %0h", name, exp, act);
      abort_run();
    end
  endtask

  // one bit per condition code, bit index is the code
  function automatic logic cond_holds(exec_pkg::cond_e code, exec_pkg::flags_t f);
    logic        lt;
    logic [15:0] truth;
    lt    = f.negative ^ f.overflow;
    truth = {1'b0, f.zero | lt, ~f.zero & ~lt, ~f.carry | f.zero,
             1'b1, f.carry & ~f.zero, ~f.overflow, f.overflow,
             ~f.negative, f.negative, ~f.carry, f.carry,
             ~lt, lt, ~f.zero, f.zero};
    return truth[code];
  endfunction

  function automatic expect_t predict(exec_pkg::instr_u ins, logic [63:0] a, logic [63:0] b_in,
                                      exec_pkg::flags_t f, int unsigned at);
    expect_t     e;
    logic [63:0] b;
    logic [64:0] wide;
    logic [63:0] r;
    logic        c;
    logic        v;
    c = 1'b0;
    v = 1'b0;
    if (ins.im.is_imm) b = 64'($signed(ins.im.imm));
    else if (ins.rg.b_sel == exec_pkg::BSEL_ONE) b = 64'd1;
    else if (ins.rg.b_sel == exec_pkg::BSEL_ZERO) b = 64'd0;
    else if (ins.rg.b_sel == exec_pkg::BSEL_ONES) b = {64{1'b1}};
    else b = b_in;
    case (ins.rg.op)
      exec_pkg::ADD: begin
        wide = {1'b0, a} + {1'b0, b};
        r = wide[63:0];
        c = wide[64];
        v = (a[63] == b[63]) && (r[63] != a[63]);
      end
      exec_pkg::SUB: begin
        wide = {1'b0, a} + {1'b0, ~b} + 65'd1; // carry means no borrow
        r = wide[63:0];
        c = wide[64];
        v = (a[63] != b[63]) && (r[63] != a[63]);
      end
      exec_pkg::AND: r = a & b;
      exec_pkg::OR:  r = a | b;
      exec_pkg::XOR: r = a ^ b;
      exec_pkg::SHL: r = a << b[5:0];
      exec_pkg::SHR: r = a >> b[5:0];
      exec_pkg::SAR: r = $signed(a) >>> b[5:0];
      exec_pkg::SXT: begin
        if (b[1:0] == 2'd0) r = 64'($signed(a[7:0]));
        else if (b[1:0] == 2'd1) r = 64'($signed(a[15:0]));
        else if (b[1:0] == 2'd2) r = 64'($signed(a[31:0]));
        else r = a;
      end
      exec_pkg::BSWAP: r = {32'd0, a[7:0], a[15:8], a[23:16], a[31:24]};
      default:         r = b; // movi
    endcase
    e.op   = ins.rg.op;
    e.cond = ins.rg.cond;
    e.tag  = ins.rg.tag;
    e.cyc  = at;
    e.exec = cond_holds(ins.rg.cond, f);
    if (e.exec) begin
      e.result         = r;
      e.flags.carry    = c;
      e.flags.overflow = v;
      e.flags.negative = r[63];
      e.flags.zero     = (r == 64'd0);
    end else begin
      e.result = a; // skipped op keeps the old value and flags
      e.flags  = f;
    end
    return e;
  endfunction

  function automatic logic [63:0] pick_operand();
    case ($urandom_range(0, 7))
      0:       return 64'd0;
      1:       return {64{1'b1}};
      2:       return 64'h7fff_ffff_ffff_ffff;
      3:       return 64'h8000_0000_0000_0000;
      4:       return 64'h0000_0000_ffff_ffff; // carry into the high half
      default: return {$urandom, $urandom};
    endcase
  endfunction

  task automatic drive_random();
    instr.rg.op     = exec_pkg::alu_op_e'($urandom_range(0, 10));
    instr.rg.cond   = ($urandom_range(0, 1) == 1) ? exec_pkg::COND_AL :
                      exec_pkg::cond_e'($urandom_range(0, 15));
    instr.rg.tag    = `EXEC_TAG_W'($urandom);
    instr.rg.is_imm = ($urandom_range(0, 3) == 0);
    if (instr.rg.is_imm) begin
      instr.im.imm = 17'($urandom);
    end else begin
      instr.rg.b_sel = exec_pkg::b_sel_e'($urandom_range(0, 3));
      instr.rg.rsvd  = 15'($urandom);
    end
    src_a    = pick_operand();
    src_b    = pick_operand();
    flags_in = exec_pkg::flags_t'(4'($urandom));
  endtask

  always @(negedge clk) begin : monitor
    expect_t e;
    string   name;
    if (!rst) begin
      assert (u_exec_cluster.u_exec_checker.fail_count == 0) else begin
        $display("a concurrent assertion on the cluster ports failed");
        abort_run();
      end
      if (result_valid) begin
        assert (exp_q.size() != 0) else begin
          $display("result_valid came with no instruction in flight");
          abort_run();
        end
        e    = exp_q.pop_front();
        name = e.exec ? e.op.name() : {e.cond.name(), " skip"};
        check_value({name, " latency"}, e.cyc, cyc);
        check_value({name, " exec"}, e.exec, result_exec);
        check_value({name, " tag"}, e.tag, result_tag);
        check_value({name, " result"}, e.result, result);
        check_value({name, " flags"}, e.flags, flags_out);
      end else if (exp_q.size() != 0) begin
        assert (cyc < exp_q[0].cyc) else begin
          $display("no result_valid for tag %0d at its expected cycle", exp_q[0].tag);
          abort_run();
        end
      end
    end
  end

  initial begin : stimulus
    int unsigned wait_cnt;
    void'($urandom(32'h1b59e3c7));
    cyc      = 0;
    rst      = 1'b1;
    issue    = 1'b0;
    instr    = '0;
    src_a    = '0;
    src_b    = '0;
    flags_in = '0;
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
    repeat (8) @(posedge clk); // idle, nothing may come out
    for (int i = 0; i < N_CYCLES; i++) begin
      @(posedge clk);
      #1;
      issue = (i >= BURST_START) || ($urandom_range(0, 99) < 70);
      drive_random();
      if (issue) exp_q.push_back(predict(instr, src_a, src_b, flags_in, cyc + `EXEC_LATENCY));
    end
    @(posedge clk);
    #1 issue = 1'b0;
    wait_cnt = 0;
    while (exp_q.size() != 0 && wait_cnt < DRAIN_LIMIT) begin
      @(posedge clk);
      wait_cnt++;
    end
    repeat (8) @(posedge clk); // stray results show up here
    if (exp_q.size() != 0) begin
      $display("timeout with %0d results still outstanding", exp_q.size());
      abort_run();
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

/* sources.f */
+incdir+common
common/exec_pkg.sv
alu_lane/cond_eval.sv
alu_lane/alu_lane.sv
hdl/op_dispatch.sv
hdl/result_merge.sv
hdl/exec_cluster.sv
testbench/exec_checker.sv
testbench/exec_cluster_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the exec_cluster testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module exec_cluster_tb -f sources.f -o sim_exec_cluster

status=0
./obj_dir/sim_exec_cluster +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Regression failed" sim.log; then
  echo "FAIL: testbench reported an error"
  exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Regression passed" sim.log; then
  echo "FAIL: simulation ended abnormally (status $status)"
  exit 1
fi
echo "PASS"
